// File: design/stat_map_pkg.sv
//################################################
// statistics register map
// address window and counter geometry of the block
//################################################

`default_nettype none

package stat_map_pkg;

  localparam int num_counters = 44;
  localparam int addr_width = 7;
  localparam int data_width = 32;

  // counters are one bit narrower than the host data word
  localparam int counter_width = 31;

  // the 44 carries are split over two host registers
  localparam int carry_lo_bits = 24;
  localparam int carry_hi_bits = 20;

  // counters occupy 0x20 up to 0x4B, one word each
  localparam logic [addr_width-1:0] counter_base = 7'h20;

  // everything up to here is acknowledged, reserved words read as zero
  localparam logic [addr_width-1:0] window_last = 7'h5F;

  localparam logic [addr_width-1:0] carry_lo_addr = 7'h4C;
  localparam logic [addr_width-1:0] carry_hi_addr = 7'h4D;
  localparam logic [addr_width-1:0] mask_lo_addr = 7'h4E;
  localparam logic [addr_width-1:0] mask_hi_addr = 7'h4F;

endpackage

`default_nettype wire

// File: design/stat_types_pkg.sv
//################################################
// statistics block types
// host words, counter values and per-counter vectors
//################################################

`default_nettype none

package stat_types_pkg;

  typedef logic [stat_map_pkg::addr_width-1:0] stat_addr_t;
  typedef logic [stat_map_pkg::data_width-1:0] stat_data_t;

  typedef logic [stat_map_pkg::counter_width-1:0] counter_value_t;
  typedef counter_value_t [stat_map_pkg::num_counters-1:0] counter_bank_t;

  // one bit per counter, used for carries and for the strobes
  typedef logic [stat_map_pkg::num_counters-1:0] counter_vec_t;

  typedef logic [stat_map_pkg::carry_lo_bits-1:0] mask_lo_t;
  typedef logic [stat_map_pkg::carry_hi_bits-1:0] mask_hi_t;

endpackage

`default_nettype wire

// File: design/stat_access_if.sv
//################################################
// synchronized host access bus
// carries the access towards the targets and their read words back
//################################################

`default_nettype none

interface stat_access_if;

  // request level after the second synchronizer stage
  logic active;
  // first cycle of active
  logic access_pulse;
  logic is_read;
  stat_types_pkg::stat_addr_t addr;
  stat_types_pkg::stat_data_t wdata;
  logic clear_all_pulse;

  // read words of the targets, zero when not addressed
  stat_types_pkg::stat_data_t rdata_counter;
  stat_types_pkg::stat_data_t rdata_carry;

  modport host (
    output active,
    output access_pulse,
    output is_read,
    output addr,
    output wdata,
    output clear_all_pulse,
    input  rdata_counter,
    input  rdata_carry
  );

  modport target (
    input  active,
    input  access_pulse,
    input  is_read,
    input  addr,
    input  wdata,
    input  clear_all_pulse,
    output rdata_counter,
    output rdata_carry
  );

endinterface

`default_nettype wire

// File: design/stat_host_sync.sv
//################################################
// host side of the statistics block
// synchronizes req and clear_all, builds ack and merges read data
//################################################

`default_nettype none

module stat_host_sync (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  logic                       read,
  input  stat_types_pkg::stat_addr_t addr,
  input  stat_types_pkg::stat_data_t wdata,
  input  logic                       clear_all,
  stat_access_if.host                acc,
  output logic                       ack,
  output stat_types_pkg::stat_data_t rdata
);

  logic req_s1;
  logic req_s2;
  logic req_s3;
  logic clr_s1;
  logic clr_s2;
  logic clr_s3;
  logic in_window;

  // req and clear_all come from another clock domain
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
      req_s3 <= 1'b0;
      clr_s1 <= 1'b0;
      clr_s2 <= 1'b0;
      clr_s3 <= 1'b0;
    end
    else
    begin
      req_s1 <= req;
      req_s2 <= req_s1;
      req_s3 <= req_s2;
      clr_s1 <= clear_all;
      clr_s2 <= clr_s1;
      clr_s3 <= clr_s2;
    end
  end

  // addr, read and wdata are held by the host for the whole request
  assign acc.active = req_s2;
  assign acc.access_pulse = req_s2 & ~req_s3;
  assign acc.is_read = read;
  assign acc.addr = addr;
  assign acc.wdata = wdata;
  assign acc.clear_all_pulse = clr_s2 & ~clr_s3;

  assign in_window = (addr >= stat_map_pkg::counter_base) &&
                     (addr <= stat_map_pkg::window_last);

  // reads wait one more stage so the counter latch is settled first
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack <= 1'b0;
    end
    else if (ack && !req_s2)
    begin
      ack <= 1'b0;
    end
    else if (!ack && in_window && ((req_s2 && !read) || (req_s3 && read)))
    begin
      ack <= 1'b1;
    end
  end

  assign rdata = (req_s2 && read) ? (acc.rdata_counter | acc.rdata_carry) : '0;

endmodule

`default_nettype wire

// File: design/stat_counter_port.sv
//################################################
// counter access port
// selects one counter, latches it for reads and drives its strobes
//################################################

`default_nettype none

module stat_counter_port (
  input  logic                          clk,
  input  logic                          rst,
  stat_access_if.target                 acc,
  input  stat_types_pkg::counter_bank_t counter_value,
  input  logic                          clear_on_read,
  output stat_types_pkg::counter_vec_t  counter_clear,
  output stat_types_pkg::counter_vec_t  counter_write
);

  stat_types_pkg::counter_vec_t   sel;
  stat_types_pkg::counter_value_t sel_value;
  stat_types_pkg::counter_value_t read_latch;
  logic                           latch_valid;
  logic                           rd_pulse;
  logic                           wr_pulse;

  // one-hot decode of 0x20..0x4B and the matching value
  always_comb
  begin
    sel = '0;
    sel_value = '0;
    for (int i = 0; i < stat_map_pkg::num_counters; i++)
    begin
      sel[i] = (acc.addr == stat_types_pkg::stat_addr_t'(stat_map_pkg::counter_base + i));
      if (sel[i])
      begin
        sel_value = sel_value | counter_value[i];
      end
    end
  end

  assign rd_pulse = acc.access_pulse & acc.is_read;
  assign wr_pulse = acc.access_pulse & ~acc.is_read;

  // the value is frozen when the read starts, the counter keeps running
  always_ff @(posedge clk)
  begin
    if (rd_pulse)
    begin
      read_latch <= sel_value;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      latch_valid <= 1'b0;
    end
    else if (rd_pulse && (|sel))
    begin
      latch_valid <= 1'b1;
    end
    else if (!acc.active)
    begin
      latch_valid <= 1'b0;
    end
  end

  assign acc.rdata_counter = latch_valid ? stat_types_pkg::stat_data_t'(read_latch) : '0;

  assign counter_write = sel & {stat_map_pkg::num_counters{wr_pulse}};

  // clear_all hits every counter at once
  assign counter_clear = (sel & {stat_map_pkg::num_counters{rd_pulse & clear_on_read}}) |
                         {stat_map_pkg::num_counters{acc.clear_all_pulse}};

endmodule

`default_nettype wire

// File: design/stat_carry_ctrl.sv
//################################################
// carry and interrupt mask registers
// write-one-to-clear carries and a level interrupt
//################################################

`default_nettype none

module stat_carry_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  stat_access_if.target                acc,
  input  stat_types_pkg::counter_vec_t carry,
  output stat_types_pkg::counter_vec_t carry_clear,
  output logic                         irq
);

  stat_types_pkg::mask_lo_t                  mask_lo;
  stat_types_pkg::mask_hi_t                  mask_hi;
  logic [stat_map_pkg::carry_lo_bits-1:0]    carry_lo;
  logic [stat_map_pkg::carry_hi_bits-1:0]    carry_hi;
  logic                                      wr_pulse;
  logic                                      sel_carry_lo;
  logic                                      sel_carry_hi;
  logic                                      sel_mask_lo;
  logic                                      sel_mask_hi;

  assign carry_lo = carry[stat_map_pkg::carry_lo_bits-1:0];
  assign carry_hi = carry[stat_map_pkg::num_counters-1:stat_map_pkg::carry_lo_bits];

  assign wr_pulse = acc.access_pulse & ~acc.is_read;
  assign sel_carry_lo = (acc.addr == stat_map_pkg::carry_lo_addr);
  assign sel_carry_hi = (acc.addr == stat_map_pkg::carry_hi_addr);
  assign sel_mask_lo = (acc.addr == stat_map_pkg::mask_lo_addr);
  assign sel_mask_hi = (acc.addr == stat_map_pkg::mask_hi_addr);

  // masks come up all ones so no interrupt fires before software sets them
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mask_lo <= '1;
      mask_hi <= '1;
    end
    else if (wr_pulse)
    begin
      if (sel_mask_lo)
      begin
        mask_lo <= acc.wdata[stat_map_pkg::carry_lo_bits-1:0];
      end
      if (sel_mask_hi)
      begin
        mask_hi <= acc.wdata[stat_map_pkg::carry_hi_bits-1:0];
      end
    end
  end

  // a one written to a carry bit clears that carry in the counter bank
  assign carry_clear[stat_map_pkg::carry_lo_bits-1:0] =
    {stat_map_pkg::carry_lo_bits{wr_pulse & sel_carry_lo}} &
    acc.wdata[stat_map_pkg::carry_lo_bits-1:0];
  assign carry_clear[stat_map_pkg::num_counters-1:stat_map_pkg::carry_lo_bits] =
    {stat_map_pkg::carry_hi_bits{wr_pulse & sel_carry_hi}} &
    acc.wdata[stat_map_pkg::carry_hi_bits-1:0];

  always_comb
  begin
    acc.rdata_carry = '0;
    if (sel_carry_lo)
      acc.rdata_carry = stat_types_pkg::stat_data_t'(carry_lo);
    if (sel_carry_hi)
      acc.rdata_carry = stat_types_pkg::stat_data_t'(carry_hi);
    if (sel_mask_lo)
      acc.rdata_carry = stat_types_pkg::stat_data_t'(mask_lo);
    if (sel_mask_hi)
      acc.rdata_carry = stat_types_pkg::stat_data_t'(mask_hi);
  end

  assign irq = |(carry & ~{mask_hi, mask_lo});

endmodule

`default_nettype wire

// File: design/stat_block.sv
//################################################
// MAC statistics register block
// host access to 44 event counters, carries and interrupt masks
//################################################

`default_nettype none

module stat_block (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic                          read,
  input  stat_types_pkg::stat_addr_t    addr,
  input  stat_types_pkg::stat_data_t    wdata,
  input  logic                          clear_on_read,
  input  logic                          clear_all,
  input  stat_types_pkg::counter_vec_t  carry,
  input  stat_types_pkg::counter_bank_t counter_value,
  output stat_types_pkg::stat_data_t    rdata,
  output logic                          ack,
  output logic                          irq,
  output stat_types_pkg::counter_vec_t  counter_clear,
  output stat_types_pkg::counter_vec_t  counter_write,
  output stat_types_pkg::counter_vec_t  carry_clear
);

  stat_access_if acc ();

  stat_host_sync i_host_sync (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .read      (read),
    .addr      (addr),
    .wdata     (wdata),
    .clear_all (clear_all),
    .acc       (acc.host),
    .ack       (ack),
    .rdata     (rdata)
  );

  stat_counter_port i_counter_port (
    .clk           (clk),
    .rst           (rst),
    .acc           (acc.target),
    .counter_value (counter_value),
    .clear_on_read (clear_on_read),
    .counter_clear (counter_clear),
    .counter_write (counter_write)
  );

  stat_carry_ctrl i_carry_ctrl (
    .clk         (clk),
    .rst         (rst),
    .acc         (acc.target),
    .carry       (carry),
    .carry_clear (carry_clear),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// File: dv/stat_block_assert.sv
//################################################
// bound checks on the host handshake and the strobes
//################################################

`default_nettype none

module stat_block_assert (
  input logic                         clk,
  input logic                         rst,
  input logic                         ack,
  input stat_types_pkg::counter_vec_t counter_write,
  input stat_types_pkg::counter_vec_t counter_clear,
  input stat_types_pkg::counter_vec_t carry_clear
);

  timeunit 1ns;
  timeprecision 1ps;

  // read back by the testbench when the run ends
  int fail_count = 0;

  ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
    else
    begin
      $error("ack is high in the cycle after reset");
      fail_count++;
    end

  // every strobe comes from a one-cycle pulse
  write_strobe_single: assert property (@(posedge clk) disable iff (rst)
    (|counter_write) |=> (counter_write == '0))
    else
    begin
      $error("counter_write is wider than one cycle");
      fail_count++;
    end

  clear_strobe_single: assert property (@(posedge clk) disable iff (rst)
    (|counter_clear) |=> (counter_clear == '0))
    else
    begin
      $error("counter_clear is wider than one cycle");
      fail_count++;
    end

  carry_clear_single: assert property (@(posedge clk) disable iff (rst)
    (|carry_clear) |=> (carry_clear == '0))
    else
    begin
      $error("carry_clear is wider than one cycle");
      fail_count++;
    end

  write_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(counter_write))
    else
    begin
      $error("counter_write has more than one bit set");
      fail_count++;
    end

endmodule

bind stat_block stat_block_assert i_assert (
  .clk           (clk),
  .rst           (rst),
  .ack           (ack),
  .counter_write (counter_write),
  .counter_clear (counter_clear),
  .carry_clear   (carry_clear)
);

`default_nettype wire

// File: dv/stat_block_tb.sv
//################################################
// testbench of the MAC statistics register block
// directed host accesses checked against counter and carry models
//################################################

`default_nettype none

module stat_block_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 20;
  localparam int ack_timeout = 16;
  localparam int num_tests = 6;
  localparam int max_accesses = 12;
  localparam int worst_access = 10;
  localparam int margin = 4;
  localparam int watchdog_ns = num_tests * max_accesses * worst_access * clk_period * margin;
  localparam logic [31:0] seed = 32'h146;

  logic                          clk;
  logic                          rst;
  logic                          req;
  logic                          read;
  stat_types_pkg::stat_addr_t    addr;
  stat_types_pkg::stat_data_t    wdata;
  logic                          clear_on_read;
  logic                          clear_all;
  stat_types_pkg::counter_vec_t  carry;
  stat_types_pkg::counter_bank_t counter_value;
  stat_types_pkg::stat_data_t    rdata;
  logic                          ack;
  logic                          irq;
  stat_types_pkg::counter_vec_t  counter_clear;
  stat_types_pkg::counter_vec_t  counter_write;
  stat_types_pkg::counter_vec_t  carry_clear;

  // strobes seen during the last host access
  stat_types_pkg::counter_vec_t clr_seen;
  stat_types_pkg::counter_vec_t wr_seen;
  stat_types_pkg::counter_vec_t cc_seen;
  logic                         acked;
  logic [31:0]                  rng_state = seed;
  int                           errors = 0;
  int                           tests_run = 0;

  stat_block i_dut (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .read          (read),
    .addr          (addr),
    .wdata         (wdata),
    .clear_on_read (clear_on_read),
    .clear_all     (clear_all),
    .carry         (carry),
    .counter_value (counter_value),
    .rdata         (rdata),
    .ack           (ack),
    .irq           (irq),
    .counter_clear (counter_clear),
    .counter_write (counter_write),
    .carry_clear   (carry_clear)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic stat_types_pkg::counter_vec_t random_vec();
    logic [63:0] w;
    w = {next_rand(), next_rand()};
    return w[stat_map_pkg::num_counters-1:0];
  endfunction

  function automatic stat_types_pkg::stat_addr_t counter_addr(input int n);
    return stat_types_pkg::stat_addr_t'(32'h20 + n);
  endfunction

  function automatic stat_types_pkg::counter_vec_t counter_bit(input int n);
    stat_types_pkg::counter_vec_t v;
    v = '0;
    v[n] = 1'b1;
    return v;
  endfunction

  function automatic void record_strobes();
    clr_seen = clr_seen | counter_clear;
    wr_seen = wr_seen | counter_write;
    cc_seen = cc_seen | carry_clear;
  endfunction

  task automatic check_data(input string name, input stat_types_pkg::stat_data_t exp,
                            input stat_types_pkg::stat_data_t act);
    if (exp !== act)
    begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_vec(input string name, input stat_types_pkg::counter_vec_t exp,
                           input stat_types_pkg::counter_vec_t act);
    if (exp !== act)
    begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // one full request and acknowledge cycle, strobes are collected on the way
  task automatic host_access(input logic is_rd, input stat_types_pkg::stat_addr_t a,
                             input stat_types_pkg::stat_data_t d,
                             output stat_types_pkg::stat_data_t rd_word);
    int waited;
    @(negedge clk);
    read = is_rd;
    addr = a;
    wdata = d;
    req = 1'b1;
    clr_seen = '0;
    wr_seen = '0;
    cc_seen = '0;
    rd_word = '0;
    waited = 0;
    while (!ack && waited < ack_timeout)
    begin
      @(negedge clk);
      record_strobes();
      waited++;
    end
    acked = ack;
    if (!ack)
    begin
      $display("no acknowledge for address %h within %0d cycles", a, ack_timeout);
      errors++;
    end
    else
      rd_word = rdata;
    req = 1'b0;
    waited = 0;
    while (ack && waited < ack_timeout)
    begin
      @(negedge clk);
      record_strobes();
      waited++;
    end
    if (ack)
    begin
      $display("acknowledge for address %h stays high after req dropped", a);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - start_errors);
  endtask

  task automatic test_reset_state();
    int start;
    stat_types_pkg::stat_data_t word;
    start = errors;
    check_bit("ack", 1'b0, ack);
    check_bit("irq", 1'b0, irq);
    host_access(1'b1, stat_map_pkg::mask_lo_addr, '0, word);
    check_data("rdata", 32'h00FF_FFFF, word);
    host_access(1'b1, stat_map_pkg::mask_hi_addr, '0, word);
    check_data("rdata", 32'h000F_FFFF, word);
    report_test("reset_state", start);
  endtask

  task automatic test_counter_read();
    int start;
    int n;
    stat_types_pkg::stat_data_t word;
    stat_types_pkg::counter_vec_t exp_clr;
    start = errors;
    for (int k = 0; k < 4; k++)
    begin
      // first and last counter, then two random ones
      n = (k < 2) ? k * 43 : int'(next_rand() % stat_map_pkg::num_counters);
      for (int cor = 0; cor < 2; cor++)
      begin
        clear_on_read = cor[0];
        host_access(1'b1, counter_addr(n), '0, word);
        check_data("rdata", {1'b0, counter_value[n]}, word);
        exp_clr = '0;
        if (cor == 1)
          exp_clr = counter_bit(n);
        check_vec("counter_clear", exp_clr, clr_seen);
        check_vec("counter_write", '0, wr_seen);
      end
    end
    clear_on_read = 1'b0;
    report_test("counter_read", start);
  endtask

  task automatic test_counter_write();
    int start;
    int n;
    stat_types_pkg::stat_addr_t a;
    stat_types_pkg::stat_data_t word;
    start = errors;
    for (int k = 0; k < 3; k++)
    begin
      n = int'(next_rand() % stat_map_pkg::num_counters);
      host_access(1'b0, counter_addr(n), next_rand(), word);
      check_bit("ack", 1'b1, acked);
      check_vec("counter_write", counter_bit(n), wr_seen);
      check_vec("counter_clear", '0, clr_seen);
    end
    // reserved words must not clear anything even with clear_on_read set
    clear_on_read = 1'b1;
    for (int k = 0; k < 2; k++)
    begin
      a = (k == 0) ? 7'h50 : 7'h5F;
      host_access(1'b0, a, next_rand(), word);
      check_bit("ack", 1'b1, acked);
      check_vec("counter_write", '0, wr_seen);
      check_vec("carry_clear", '0, cc_seen);
      host_access(1'b1, a, '0, word);
      check_bit("ack", 1'b1, acked);
      check_data("rdata", '0, word);
      check_vec("counter_clear", '0, clr_seen);
    end
    clear_on_read = 1'b0;
    report_test("counter_write", start);
  endtask

  task automatic test_carry();
    int start;
    stat_types_pkg::stat_data_t word;
    stat_types_pkg::stat_data_t w;
    stat_types_pkg::counter_vec_t exp;
    start = errors;
    carry = random_vec();
    host_access(1'b1, stat_map_pkg::carry_lo_addr, '0, word);
    check_data("rdata", {8'h00, carry[23:0]}, word);
    host_access(1'b1, stat_map_pkg::carry_hi_addr, '0, word);
    check_data("rdata", {12'h000, carry[43:24]}, word);
    w = next_rand();
    host_access(1'b0, stat_map_pkg::carry_hi_addr, w, word);
    exp = '0;
    exp[43:24] = w[19:0];
    check_vec("carry_clear", exp, cc_seen);
    w = next_rand();
    host_access(1'b0, stat_map_pkg::carry_lo_addr, w, word);
    exp = '0;
    exp[23:0] = w[23:0];
    check_vec("carry_clear", exp, cc_seen);
    report_test("carry", start);
  endtask

  task automatic test_mask_irq();
    int start;
    stat_types_pkg::stat_data_t word;
    stat_types_pkg::stat_data_t mlo;
    stat_types_pkg::stat_data_t mhi;
    start = errors;
    for (int k = 0; k < 2; k++)
    begin
      mlo = next_rand();
      mhi = next_rand();
      host_access(1'b0, stat_map_pkg::mask_lo_addr, mlo, word);
      host_access(1'b0, stat_map_pkg::mask_hi_addr, mhi, word);
      host_access(1'b1, stat_map_pkg::mask_lo_addr, '0, word);
      check_data("rdata", {8'h00, mlo[23:0]}, word);
      host_access(1'b1, stat_map_pkg::mask_hi_addr, '0, word);
      check_data("rdata", {12'h000, mhi[19:0]}, word);
      for (int j = 0; j < 4; j++)
      begin
        // pending carries that are all masked must keep irq low
        if (j == 0)
          carry = '0;
        else if (j == 1)
          carry = {mhi[19:0], mlo[23:0]};
        else
          carry = random_vec();
        @(negedge clk);
        check_bit("irq", |(carry & ~{mhi[19:0], mlo[23:0]}), irq);
      end
    end
    report_test("mask_irq", start);
  endtask

  task automatic test_clear_all();
    int start;
    int ones_cycles;
    stat_types_pkg::counter_vec_t partial;
    start = errors;
    ones_cycles = 0;
    partial = '0;
    clear_all = 1'b1;
    for (int j = 0; j < 8; j++)
    begin
      @(negedge clk);
      if (counter_clear == '1)
        ones_cycles++;
      else
        partial = partial | counter_clear;
      if (j == 3)
        clear_all = 1'b0;
    end
    check_bit("counter_clear single all-ones cycle", 1'b1, ones_cycles == 1);
    check_vec("counter_clear outside the pulse", '0, partial);
    report_test("clear_all", start);
  endtask

  initial
  begin
    int assert_errors;
    rst = 1'b1;
    req = 1'b0;
    read = 1'b0;
    addr = '0;
    wdata = '0;
    clear_on_read = 1'b0;
    clear_all = 1'b0;
    // every carry pending, so only the reset masks keep irq low
    carry = '1;
    for (int i = 0; i < stat_map_pkg::num_counters; i++)
      counter_value[i] = stat_types_pkg::counter_value_t'(next_rand());
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_counter_read();
    test_counter_write();
    test_carry();
    test_mask_irq();
    test_clear_all();

    assert_errors = i_dut.i_assert.fail_count;
    $display("%0d tests run, %0d check errors, %0d assertion errors",
             tests_run, errors, assert_errors);
    if (errors == 0 && assert_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
design/stat_map_pkg.sv
design/stat_types_pkg.sv
design/stat_access_if.sv
design/stat_host_sync.sv
design/stat_counter_port.sv
design/stat_carry_ctrl.sv
design/stat_block.sv
dv/stat_block_assert.sv
dv/stat_block_tb.sv

// File: Bender.yml
package:
  name: stat_block

sources:
  - design/stat_map_pkg.sv
  - design/stat_types_pkg.sv
  - design/stat_access_if.sv
  - design/stat_host_sync.sv
  - design/stat_counter_port.sv
  - design/stat_carry_ctrl.sv
  - design/stat_block.sv
  - target: simulation
    files:
      - dv/stat_block_assert.sv
      - dv/stat_block_tb.sv
